//--- soc_defines.svh
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// ********************
// memory map with one window per target
// ********************

`define UART_BASE  32'h1000_0000
`define UART_SIZE  32'h0000_1000

`define CLINT_BASE 32'h0200_0000
`define CLINT_SIZE 32'h0001_0000

`define TIM0_BASE  32'h8000_0000
`define TIM1_BASE  32'h8000_1000
`define TIM_WORDS  1024
`define TIM_SIZE   32'h0000_1000 // tim words times four bytes.

// ********************
// clint register offsets
// ********************

`define CLINT_MSIP        32'h0000_0000
`define CLINT_MTIMECMP_LO 32'h0000_4000
`define CLINT_MTIMECMP_HI 32'h0000_4004
`define CLINT_MTIME_LO    32'h0000_BFF8
`define CLINT_MTIME_HI    32'h0000_BFFC

`define MTIME_DIVIDER 4 // clock cycles per mtime step.

`endif

//--- soc_pkg.sv
`default_nettype none

package soc_pkg;

  // ********************
  // bus payload
  // ********************

  typedef logic [31:0] bus_addr_t; // byte address.
  typedef logic [31:0] bus_data_t;
  typedef logic [3:0]  bus_strb_t; // zero strobes mean a read.

  // ********************
  // arbiter ownership
  // ********************

  typedef enum logic [1:0] {
    grant_none,
    grant_instr,
    grant_data
  } grant_t;

endpackage

`default_nettype wire

//--- bus_decoder.sv
`timescale 1ns/100ps
`include "soc_defines.svh"
`default_nettype none

module bus_decoder import soc_pkg::*; (
  input  logic      m_valid,
  input  bus_addr_t m_addr,
  input  bus_data_t m_wdata,
  input  bus_strb_t m_wstrb,
  output bus_data_t m_rdata,
  output logic      m_ready,
  output logic      tim0_valid,
  output logic      tim1_valid,
  output logic      clint_valid,
  output logic      uart_valid,
  output bus_addr_t offset,
  output bus_data_t wdata,
  output bus_strb_t wstrb,
  input  bus_data_t tim0_rdata,
  input  bus_data_t tim1_rdata,
  input  bus_data_t clint_rdata,
  input  bus_data_t uart_rdata,
  input  logic      tim0_ready,
  input  logic      tim1_ready,
  input  logic      clint_ready,
  input  logic      uart_ready
);

  bus_addr_t base;

  always_comb begin
    tim0_valid  = 1'b0;
    tim1_valid  = 1'b0;
    clint_valid = 1'b0;
    uart_valid  = 1'b0;
    base        = '0;
    if (m_valid) begin
      if (m_addr >= `TIM1_BASE && m_addr < `TIM1_BASE + `TIM_SIZE) begin
        tim1_valid = 1'b1;
        base       = `TIM1_BASE;
      end else if (m_addr >= `TIM0_BASE && m_addr < `TIM0_BASE + `TIM_SIZE) begin
        tim0_valid = 1'b1;
        base       = `TIM0_BASE;
      end else if (m_addr >= `CLINT_BASE && m_addr < `CLINT_BASE + `CLINT_SIZE) begin
        clint_valid = 1'b1;
        base        = `CLINT_BASE;
      end else if (m_addr >= `UART_BASE && m_addr < `UART_BASE + `UART_SIZE) begin
        uart_valid = 1'b1;
        base       = `UART_BASE;
      end
    end
  end

  assign offset = m_addr - base;
  assign wdata  = m_wdata;
  assign wstrb  = m_wstrb;

  // only one target answers a given master at a time.
  always_comb begin
    m_rdata = '0;
    m_ready = 1'b0;
    if (tim1_ready) begin
      m_rdata = tim1_rdata;
      m_ready = 1'b1;
    end else if (tim0_ready) begin
      m_rdata = tim0_rdata;
      m_ready = 1'b1;
    end else if (clint_ready) begin
      m_rdata = clint_rdata;
      m_ready = 1'b1;
    end else if (uart_ready) begin
      m_rdata = uart_rdata;
      m_ready = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- bus_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module bus_arbiter import soc_pkg::*; (
  input  logic      clock,
  input  logic      arst_n,
  input  logic      i_valid,
  input  bus_addr_t i_addr,
  input  bus_data_t i_wdata,
  input  bus_strb_t i_wstrb,
  output bus_data_t i_rdata,
  output logic      i_ready,
  input  logic      d_valid,
  input  bus_addr_t d_addr,
  input  bus_data_t d_wdata,
  input  bus_strb_t d_wstrb,
  output bus_data_t d_rdata,
  output logic      d_ready,
  output logic      t_valid,
  output bus_addr_t t_addr,
  output bus_data_t t_wdata,
  output bus_strb_t t_wstrb,
  input  bus_data_t t_rdata,
  input  logic      t_ready
);

  grant_t grant_q;
  grant_t owner;

  // ********************
  // grant
  // ********************

  // a held grant wins, otherwise data beats instr on a tie.
  always_comb begin
    owner = grant_q;
    if (grant_q == grant_none) begin
      if (d_valid) begin
        owner = grant_data;
      end else if (i_valid) begin
        owner = grant_instr;
      end
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      grant_q <= grant_none;
    end else if (t_ready) begin
      grant_q <= grant_none; // transfer done.
    end else begin
      grant_q <= owner;
    end
  end

  // ********************
  // request and response paths
  // ********************

  always_comb begin
    t_valid = 1'b0;
    t_addr  = d_addr;
    t_wdata = d_wdata;
    t_wstrb = d_wstrb;
    case (owner)
      grant_data: begin
        t_valid = d_valid;
      end
      grant_instr: begin
        t_valid = i_valid;
        t_addr  = i_addr;
        t_wdata = i_wdata;
        t_wstrb = i_wstrb;
      end
      default: begin
        t_valid = 1'b0;
      end
    endcase
  end

  assign i_rdata = t_rdata;
  assign d_rdata = t_rdata;
  assign i_ready = t_ready && (owner == grant_instr);
  assign d_ready = t_ready && (owner == grant_data);

endmodule

`default_nettype wire

//--- tim.sv
`timescale 1ns/100ps
`include "soc_defines.svh"
`default_nettype none

module tim import soc_pkg::*; (
  input  logic      clock,
  input  logic      arst_n,
  input  logic      valid,
  input  bus_addr_t addr,
  input  bus_data_t wdata,
  input  bus_strb_t wstrb,
  output bus_data_t rdata,
  output logic      ready
);

  localparam int index_bits = $clog2(`TIM_WORDS);

  bus_data_t             mem [`TIM_WORDS];
  logic [index_bits-1:0] index;
  logic                  accept;

  assign index  = addr[index_bits+1:2]; // word offset.
  assign accept = valid && !ready;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      ready <= 1'b0;
    end else begin
      ready <= accept;
    end
  end

  // ********************
  // storage
  // ********************

  always_ff @(posedge clock) begin
    if (accept) begin
      rdata <= mem[index]; // old word even on a write.
      for (int b = 0; b < $bits(bus_strb_t); b++) begin
        if (wstrb[b]) begin
          mem[index][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- clint.sv
`timescale 1ns/100ps
`include "soc_defines.svh"
`default_nettype none

module clint import soc_pkg::*; #(
  parameter int tick_divider = `MTIME_DIVIDER
) (
  input  logic        clock,
  input  logic        arst_n,
  input  logic        valid,
  input  bus_addr_t   addr,
  input  bus_data_t   wdata,
  input  bus_strb_t   wstrb,
  output bus_data_t   rdata,
  output logic        ready,
  output logic        msip,
  output logic        mtip,
  output logic [63:0] mtime
);

  localparam int count_bits = (tick_divider > 1) ? $clog2(tick_divider) : 1;

  logic [count_bits-1:0] prescale;
  logic                  tick;
  logic                  accept;
  logic                  write;
  logic [63:0]           mtimecmp;
  bus_data_t             read_word;

  function automatic bus_data_t merge(bus_data_t old, bus_data_t data, bus_strb_t strb);
    bus_data_t result;
    result = old;
    for (int b = 0; b < $bits(bus_strb_t); b++) begin
      if (strb[b]) begin
        result[8*b +: 8] = data[8*b +: 8];
      end
    end
    return result;
  endfunction

  assign accept = valid && !ready;
  assign write  = accept && (wstrb != '0);
  assign tick   = (prescale == count_bits'(tick_divider - 1));

  // ********************
  // mtime prescaler
  // ********************

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      prescale <= '0;
    end else if (tick) begin
      prescale <= '0;
    end else begin
      prescale <= prescale + 1'b1;
    end
  end

  // ********************
  // registers
  // ********************

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      ready    <= 1'b0;
      msip     <= 1'b0;
      mtip     <= 1'b0;
      mtime    <= '0;
      mtimecmp <= '1; // no timer interrupt until programmed.
    end else begin
      ready <= accept;
      mtip  <= (mtime >= mtimecmp);
      if (write && addr == `CLINT_MSIP && wstrb[0]) begin
        msip <= wdata[0];
      end
      if (write && addr == `CLINT_MTIMECMP_LO) begin
        mtimecmp[31:0] <= merge(mtimecmp[31:0], wdata, wstrb);
      end
      if (write && addr == `CLINT_MTIMECMP_HI) begin
        mtimecmp[63:32] <= merge(mtimecmp[63:32], wdata, wstrb);
      end
      if (write && addr == `CLINT_MTIME_LO) begin
        mtime[31:0] <= merge(mtime[31:0], wdata, wstrb); // writes beat the tick.
      end else if (write && addr == `CLINT_MTIME_HI) begin
        mtime[63:32] <= merge(mtime[63:32], wdata, wstrb);
      end else if (tick) begin
        mtime <= mtime + 64'd1;
      end
    end
  end

  always_comb begin
    case (addr)
      `CLINT_MSIP:        read_word = {31'b0, msip};
      `CLINT_MTIMECMP_LO: read_word = mtimecmp[31:0];
      `CLINT_MTIMECMP_HI: read_word = mtimecmp[63:32];
      `CLINT_MTIME_LO:    read_word = mtime[31:0];
      `CLINT_MTIME_HI:    read_word = mtime[63:32];
      default:            read_word = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      rdata <= read_word;
    end
  end

endmodule

`default_nettype wire

//--- soc.sv
`timescale 1ns/100ps
`default_nettype none

module soc import soc_pkg::*; (
  input  logic        clock,
  input  logic        arst_n,
  input  logic        imem_valid,
  input  bus_addr_t   imem_addr,
  input  bus_data_t   imem_wdata,
  input  bus_strb_t   imem_wstrb,
  output bus_data_t   imem_rdata,
  output logic        imem_ready,
  input  logic        dmem_valid,
  input  bus_addr_t   dmem_addr,
  input  bus_data_t   dmem_wdata,
  input  bus_strb_t   dmem_wstrb,
  output bus_data_t   dmem_rdata,
  output logic        dmem_ready,
  output logic        uart_valid,
  output bus_addr_t   uart_addr,
  output bus_data_t   uart_wdata,
  output bus_strb_t   uart_wstrb,
  input  bus_data_t   uart_rdata,
  input  logic        uart_ready,
  output logic        msip,
  output logic        mtip,
  output logic [63:0] mtime
);

  // ********************
  // decoder side, per master
  // ********************

  bus_addr_t i_offset, d_offset;
  bus_data_t i_wdata, d_wdata;
  bus_strb_t i_wstrb, d_wstrb;

  logic      itim0_valid, itim1_valid, iclint_valid, iuart_valid;
  logic      dtim0_valid, dtim1_valid, dclint_valid, duart_valid;
  bus_data_t itim0_rdata, itim1_rdata, iclint_rdata, iuart_rdata;
  bus_data_t dtim0_rdata, dtim1_rdata, dclint_rdata, duart_rdata;
  logic      itim0_ready, itim1_ready, iclint_ready, iuart_ready;
  logic      dtim0_ready, dtim1_ready, dclint_ready, duart_ready;

  // ********************
  // target side
  // ********************

  logic      tim0_valid, tim1_valid, clint_valid;
  bus_addr_t tim0_addr, tim1_addr, clint_addr;
  bus_data_t tim0_wdata, tim1_wdata, clint_wdata;
  bus_strb_t tim0_wstrb, tim1_wstrb, clint_wstrb;
  bus_data_t tim0_rdata, tim1_rdata, clint_rdata;
  logic      tim0_ready, tim1_ready, clint_ready;

  bus_decoder decoder_imem_comp (
    .m_valid(imem_valid), .m_addr(imem_addr), .m_wdata(imem_wdata), .m_wstrb(imem_wstrb),
    .m_rdata(imem_rdata), .m_ready(imem_ready),
    .tim0_valid(itim0_valid), .tim1_valid(itim1_valid),
    .clint_valid(iclint_valid), .uart_valid(iuart_valid),
    .offset(i_offset), .wdata(i_wdata), .wstrb(i_wstrb),
    .tim0_rdata(itim0_rdata), .tim1_rdata(itim1_rdata),
    .clint_rdata(iclint_rdata), .uart_rdata(iuart_rdata),
    .tim0_ready(itim0_ready), .tim1_ready(itim1_ready),
    .clint_ready(iclint_ready), .uart_ready(iuart_ready)
  );

  bus_decoder decoder_dmem_comp (
    .m_valid(dmem_valid), .m_addr(dmem_addr), .m_wdata(dmem_wdata), .m_wstrb(dmem_wstrb),
    .m_rdata(dmem_rdata), .m_ready(dmem_ready),
    .tim0_valid(dtim0_valid), .tim1_valid(dtim1_valid),
    .clint_valid(dclint_valid), .uart_valid(duart_valid),
    .offset(d_offset), .wdata(d_wdata), .wstrb(d_wstrb),
    .tim0_rdata(dtim0_rdata), .tim1_rdata(dtim1_rdata),
    .clint_rdata(dclint_rdata), .uart_rdata(duart_rdata),
    .tim0_ready(dtim0_ready), .tim1_ready(dtim1_ready),
    .clint_ready(dclint_ready), .uart_ready(duart_ready)
  );

  bus_arbiter arbiter_tim0_comp (
    .clock(clock), .arst_n(arst_n),
    .i_valid(itim0_valid), .i_addr(i_offset), .i_wdata(i_wdata), .i_wstrb(i_wstrb),
    .i_rdata(itim0_rdata), .i_ready(itim0_ready),
    .d_valid(dtim0_valid), .d_addr(d_offset), .d_wdata(d_wdata), .d_wstrb(d_wstrb),
    .d_rdata(dtim0_rdata), .d_ready(dtim0_ready),
    .t_valid(tim0_valid), .t_addr(tim0_addr), .t_wdata(tim0_wdata), .t_wstrb(tim0_wstrb),
    .t_rdata(tim0_rdata), .t_ready(tim0_ready)
  );

  bus_arbiter arbiter_tim1_comp (
    .clock(clock), .arst_n(arst_n),
    .i_valid(itim1_valid), .i_addr(i_offset), .i_wdata(i_wdata), .i_wstrb(i_wstrb),
    .i_rdata(itim1_rdata), .i_ready(itim1_ready),
    .d_valid(dtim1_valid), .d_addr(d_offset), .d_wdata(d_wdata), .d_wstrb(d_wstrb),
    .d_rdata(dtim1_rdata), .d_ready(dtim1_ready),
    .t_valid(tim1_valid), .t_addr(tim1_addr), .t_wdata(tim1_wdata), .t_wstrb(tim1_wstrb),
    .t_rdata(tim1_rdata), .t_ready(tim1_ready)
  );

  bus_arbiter arbiter_clint_comp (
    .clock(clock), .arst_n(arst_n),
    .i_valid(iclint_valid), .i_addr(i_offset), .i_wdata(i_wdata), .i_wstrb(i_wstrb),
    .i_rdata(iclint_rdata), .i_ready(iclint_ready),
    .d_valid(dclint_valid), .d_addr(d_offset), .d_wdata(d_wdata), .d_wstrb(d_wstrb),
    .d_rdata(dclint_rdata), .d_ready(dclint_ready),
    .t_valid(clint_valid), .t_addr(clint_addr), .t_wdata(clint_wdata), .t_wstrb(clint_wstrb),
    .t_rdata(clint_rdata), .t_ready(clint_ready)
  );

  // uart target lives outside the chip.
  bus_arbiter arbiter_uart_comp (
    .clock(clock), .arst_n(arst_n),
    .i_valid(iuart_valid), .i_addr(i_offset), .i_wdata(i_wdata), .i_wstrb(i_wstrb),
    .i_rdata(iuart_rdata), .i_ready(iuart_ready),
    .d_valid(duart_valid), .d_addr(d_offset), .d_wdata(d_wdata), .d_wstrb(d_wstrb),
    .d_rdata(duart_rdata), .d_ready(duart_ready),
    .t_valid(uart_valid), .t_addr(uart_addr), .t_wdata(uart_wdata), .t_wstrb(uart_wstrb),
    .t_rdata(uart_rdata), .t_ready(uart_ready)
  );

  tim tim0_comp (
    .clock(clock), .arst_n(arst_n),
    .valid(tim0_valid), .addr(tim0_addr), .wdata(tim0_wdata), .wstrb(tim0_wstrb),
    .rdata(tim0_rdata), .ready(tim0_ready)
  );

  tim tim1_comp (
    .clock(clock), .arst_n(arst_n),
    .valid(tim1_valid), .addr(tim1_addr), .wdata(tim1_wdata), .wstrb(tim1_wstrb),
    .rdata(tim1_rdata), .ready(tim1_ready)
  );

  clint clint_comp (
    .clock(clock), .arst_n(arst_n),
    .valid(clint_valid), .addr(clint_addr), .wdata(clint_wdata), .wstrb(clint_wstrb),
    .rdata(clint_rdata), .ready(clint_ready),
    .msip(msip), .mtip(mtip), .mtime(mtime)
  );

endmodule

`default_nettype wire

//--- soc_checker.sv
`timescale 1ns/100ps
`default_nettype none

module soc_checker import soc_pkg::*; (
  input logic        clock,
  input logic        arst_n,
  input logic        imem_valid,
  input logic        imem_ready,
  input logic        dmem_valid,
  input logic        dmem_ready,
  input logic        uart_valid,
  input bus_addr_t   uart_addr,
  input bus_data_t   uart_wdata,
  input bus_strb_t   uart_wstrb,
  input logic        uart_ready,
  input logic        msip,
  input logic [63:0] mtime
);

  // ********************
  // handshake
  // ********************

  imem_ready_pulse: assert property (@(posedge clock) disable iff (!arst_n)
    imem_ready |=> !imem_ready) else $error("imem_ready high for more than one cycle");

  dmem_ready_pulse: assert property (@(posedge clock) disable iff (!arst_n)
    dmem_ready |=> !dmem_ready) else $error("dmem_ready high for more than one cycle");

  imem_valid_held: assert property (@(posedge clock) disable iff (!arst_n)
    imem_valid && !imem_ready |=> imem_valid) else $error("imem_valid dropped before ready");

  dmem_valid_held: assert property (@(posedge clock) disable iff (!arst_n)
    dmem_valid && !dmem_ready |=> dmem_valid) else $error("dmem_valid dropped before ready");

  // the outside device sees one steady request per transfer.
  uart_request_stable: assert property (@(posedge clock) disable iff (!arst_n)
    uart_valid && !uart_ready |=> uart_valid && $stable(uart_addr) && $stable(uart_wdata)
      && $stable(uart_wstrb)) else $error("uart request changed before uart_ready");

  // ********************
  // interrupts
  // ********************

  mtime_steps: assert property (@(posedge clock) disable iff (!arst_n)
    mtime == $past(mtime) || mtime == $past(mtime) + 64'd1)
    else $error("mtime moved by more than one step");

  msip_from_bus: assert property (@(posedge clock) disable iff (!arst_n)
    $rose(msip) |-> $past(imem_valid || dmem_valid))
    else $error("msip rose without a bus request");

endmodule

bind soc soc_checker checker0 (
  .clock(clock),
  .arst_n(arst_n),
  .imem_valid(imem_valid),
  .imem_ready(imem_ready),
  .dmem_valid(dmem_valid),
  .dmem_ready(dmem_ready),
  .uart_valid(uart_valid),
  .uart_addr(uart_addr),
  .uart_wdata(uart_wdata),
  .uart_wstrb(uart_wstrb),
  .uart_ready(uart_ready),
  .msip(msip),
  .mtime(mtime)
);

`default_nettype wire

//--- soc_tb.sv
`timescale 1ns/100ps
`include "soc_defines.svh"
`default_nettype none

module soc_tb
  import soc_pkg::*;
();

  localparam int num_slots        = 16;
  localparam int num_random_ops   = 60;
  localparam int num_transactions = 2 * num_slots + num_random_ops + 4 + 6 + 7;
  localparam int mtime_cycles     = 10 * `MTIME_DIVIDER + 2;
  localparam int watchdog_cycles  = 200 * num_transactions + mtime_cycles;

  logic        clock;
  logic        arst_n;
  logic        imem_valid;
  bus_addr_t   imem_addr;
  bus_data_t   imem_wdata;
  bus_strb_t   imem_wstrb;
  bus_data_t   imem_rdata;
  logic        imem_ready;
  logic        dmem_valid;
  bus_addr_t   dmem_addr;
  bus_data_t   dmem_wdata;
  bus_strb_t   dmem_wstrb;
  bus_data_t   dmem_rdata;
  logic        dmem_ready;
  logic        uart_valid;
  bus_addr_t   uart_addr;
  bus_data_t   uart_wdata;
  bus_strb_t   uart_wstrb;
  bus_data_t   uart_rdata;
  logic        uart_ready;
  logic        msip;
  logic        mtip;
  logic [63:0] mtime;

  bus_data_t tim_model [2][`TIM_WORDS]; // expected contents of tim0 and tim1.
  int        slot_word [2][num_slots];  // words the random phase works on.

  bus_addr_t uart_req_addr; // request the uart model took last.
  bus_data_t uart_req_wdata;
  bus_strb_t uart_req_wstrb;

  soc dut0 (.*);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  initial begin
    #(watchdog_cycles * 100);
    $display("watchdog expired before all transactions completed");
    $display("TEST FAILED");
    $fatal(1, "timeout");
  end

  // ********************
  // uart device model
  // ********************

  initial begin
    logic      seen_valid;
    bus_addr_t seen_addr;
    bus_data_t seen_wdata;
    bus_strb_t seen_wstrb;
    logic      busy;
    uart_ready     = 1'b0;
    uart_rdata     = '0;
    busy           = 1'b0;
    uart_req_addr  = '0;
    uart_req_wdata = '0;
    uart_req_wstrb = '0;
    forever begin
      @(posedge clock);
      seen_valid = uart_valid;
      seen_addr  = uart_addr;
      seen_wdata = uart_wdata;
      seen_wstrb = uart_wstrb;
      @(negedge clock);
      if (uart_ready) begin
        uart_ready = 1'b0; // one cycle pulse.
      end else if (busy) begin
        uart_ready = 1'b1;
        uart_rdata = uart_req_addr ^ 32'hA5A5_0000;
        busy       = 1'b0;
      end else if (seen_valid) begin
        busy           = 1'b1;
        uart_req_addr  = seen_addr;
        uart_req_wdata = seen_wdata;
        uart_req_wstrb = seen_wstrb;
      end
    end
  end

  // ********************
  // helpers
  // ********************

  function automatic bus_data_t strobe_mask(bus_strb_t strb);
    bus_data_t mask;
    for (int b = 0; b < 4; b++) begin
      mask[8*b +: 8] = {8{strb[b]}};
    end
    return mask;
  endfunction

  task automatic expect_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
    assert (actual === expected) else begin
      $display("FAIL %0t %s expected %0h actual %0h", $time, name, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic expect_true(input bit condition, input string what);
    assert (condition) else begin
      $display("%0t %s", $time, what);
      $display("TEST FAILED");
      $fatal(1, "%s", what);
    end
  endtask

  // waits counts the cycles between the first sampled valid and ready.
  task automatic bus_access(input bit use_data, input bus_addr_t addr, input bus_data_t wdata,
                            input bus_strb_t wstrb, output bus_data_t rdata, output int waits);
    @(negedge clock);
    if (use_data) begin
      dmem_addr  = addr;
      dmem_wdata = wdata;
      dmem_wstrb = wstrb;
      dmem_valid = 1'b1;
    end else begin
      imem_addr  = addr;
      imem_wdata = wdata;
      imem_wstrb = wstrb;
      imem_valid = 1'b1;
    end
    waits = 0;
    @(posedge clock);
    while (!(use_data ? dmem_ready : imem_ready)) begin
      waits++;
      @(posedge clock);
    end
    rdata = use_data ? dmem_rdata : imem_rdata;
    @(negedge clock);
    if (use_data) begin
      dmem_valid = 1'b0;
    end else begin
      imem_valid = 1'b0;
    end
  endtask

  task automatic tim_op(input int which, input int slot, input bit use_data,
                        input bus_data_t wdata, input bus_strb_t wstrb, input bit known);
    bus_addr_t addr;
    bus_data_t rdata;
    bus_data_t mask;
    int        word;
    int        waits;
    word = slot_word[which][slot];
    addr = (which == 1 ? `TIM1_BASE : `TIM0_BASE) + 32'(word * 4);
    bus_access(use_data, addr, wdata, wstrb, rdata, waits);
    if (known) begin
      expect_value(use_data ? "dmem_rdata" : "imem_rdata", 64'(tim_model[which][word]),
                   64'(rdata)); // the old word even on a write.
    end
    expect_value("uncontended latency", 64'(1), 64'(waits));
    mask = strobe_mask(wstrb);
    tim_model[which][word] = (tim_model[which][word] & ~mask) | (wdata & mask);
  endtask

  task automatic contend_tim0(input int slot);
    bus_addr_t addr;
    bus_data_t d_data;
    bus_strb_t d_strb;
    bus_data_t old_word;
    bus_data_t new_word;
    bus_data_t d_rdata;
    bus_data_t i_rdata;
    int        d_waits;
    int        i_waits;
    addr     = `TIM0_BASE + 32'(slot_word[0][slot] * 4);
    d_data   = $urandom();
    d_strb   = 4'($urandom()) | 4'h1;
    old_word = tim_model[0][slot_word[0][slot]];
    new_word = (old_word & ~strobe_mask(d_strb)) | (d_data & strobe_mask(d_strb));
    fork
      bus_access(1'b1, addr, d_data, d_strb, d_rdata, d_waits);
      bus_access(1'b0, addr, '0, '0, i_rdata, i_waits);
    join
    expect_true(d_waits < i_waits, "dmem did not win the tie on tim0");
    expect_value("dmem_rdata", 64'(old_word), 64'(d_rdata));
    expect_value("imem_rdata", 64'(new_word), 64'(i_rdata)); // sees the data write.
    tim_model[0][slot_word[0][slot]] = new_word;
  endtask

  task automatic uart_op(input bit use_data, input bus_addr_t offset, input bus_data_t wdata,
                         input bus_strb_t wstrb);
    bus_data_t rdata;
    int        waits;
    bus_access(use_data, `UART_BASE + offset, wdata, wstrb, rdata, waits);
    expect_value("uart_addr", 64'(offset), 64'(uart_req_addr));
    expect_value("uart_wdata", 64'(wdata), 64'(uart_req_wdata));
    expect_value("uart_wstrb", 64'(wstrb), 64'(uart_req_wstrb));
    expect_value(use_data ? "dmem_rdata" : "imem_rdata", 64'(offset ^ 32'hA5A5_0000),
                 64'(rdata));
  endtask

  // ********************
  // test sequence
  // ********************

  initial begin
    bus_data_t   rdata;
    bus_strb_t   strb;
    logic [63:0] expected_time;
    logic [63:0] target;
    int          waits;
    int          which;
    int          slot;
    void'($urandom(71591));
    arst_n     = 1'b0;
    imem_valid = 1'b0;
    imem_addr  = '0;
    imem_wdata = '0;
    imem_wstrb = '0;
    dmem_valid = 1'b0;
    dmem_addr  = '0;
    dmem_wdata = '0;
    dmem_wstrb = '0;
    repeat (4) @(negedge clock);
    expect_value("imem_ready", 64'(0), 64'(imem_ready));
    expect_value("dmem_ready", 64'(0), 64'(dmem_ready));
    expect_value("uart_valid", 64'(0), 64'(uart_valid));
    expect_value("msip", 64'(0), 64'(msip));
    expect_value("mtip", 64'(0), 64'(mtip));
    expect_value("mtime", 64'(0), mtime);
    arst_n = 1'b1;

    for (int t = 0; t < 2; t++) begin
      for (int s = 0; s < num_slots; s++) begin
        slot_word[t][s] = $urandom_range(`TIM_WORDS - 1, 0);
        tim_op(t, s, 1'(s), $urandom(), 4'hf, 1'b0); // fill with whole words first.
      end
    end
    repeat (num_random_ops) begin
      which = $urandom_range(1, 0);
      slot  = $urandom_range(num_slots - 1, 0);
      strb  = ($urandom_range(2, 0) == 0) ? 4'h0 : 4'($urandom());
      tim_op(which, slot, 1'($urandom()), $urandom(), strb, 1'b1);
    end

    contend_tim0(0);
    contend_tim0(5);

    uart_op(1'b1, 32'h0000_0000, '0, '0);
    uart_op(1'b0, 32'h0000_0004, $urandom(), 4'hf);
    uart_op(1'b0, 32'h0000_0ffc, '0, '0);
    uart_op(1'b1, 32'h0000_0120, $urandom(), 4'h3);
    fork
      uart_op(1'b1, 32'h0000_0008, $urandom(), 4'h1);
      uart_op(1'b0, 32'h0000_0010, '0, '0);
    join

    bus_access(1'b1, `CLINT_BASE + `CLINT_MSIP, 32'h1, 4'h1, rdata, waits);
    expect_value("msip", 64'(1), 64'(msip));
    bus_access(1'b0, `CLINT_BASE + `CLINT_MSIP, '0, '0, rdata, waits);
    expect_value("imem_rdata", 64'(1), 64'(rdata));
    @(posedge clock);
    expected_time = mtime;
    repeat (3) begin
      repeat (`MTIME_DIVIDER) @(posedge clock);
      expected_time = expected_time + 64'd1;
      expect_value("mtime", expected_time, mtime);
    end

    target = mtime + 64'd5;
    bus_access(1'b1, `CLINT_BASE + `CLINT_MTIMECMP_LO, target[31:0], 4'hf, rdata, waits);
    bus_access(1'b1, `CLINT_BASE + `CLINT_MTIMECMP_HI, target[63:32], 4'hf, rdata, waits);
    expect_value("mtip", 64'(0), 64'(mtip));
    waits = 0;
    while (!mtip) begin
      @(posedge clock);
      waits++;
      expect_true(waits <= 5 * `MTIME_DIVIDER + 2, "mtip did not rise in time");
    end
    expect_true(mtime >= target, "mtip rose before mtime reached mtimecmp");
    bus_access(1'b0, `CLINT_BASE + `CLINT_MTIMECMP_LO, '0, '0, rdata, waits);
    expect_value("imem_rdata", 64'(target[31:0]), 64'(rdata));
    bus_access(1'b1, `CLINT_BASE + `CLINT_MTIMECMP_LO, 32'hffff_ffff, 4'hf, rdata, waits);
    bus_access(1'b1, `CLINT_BASE + `CLINT_MTIMECMP_HI, 32'hffff_ffff, 4'hf, rdata, waits);
    @(posedge clock);
    expect_value("mtip", 64'(0), 64'(mtip));

    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+.
soc_pkg.sv
bus_decoder.sv
bus_arbiter.sv
tim.sv
clint.sv
soc.sv
soc_checker.sv
soc_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the soc testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module soc_tb -f sim.f -o soc_sim

./obj_dir/soc_sim
